// ==== verilog/adc_chan_settings.svh ====
`ifndef ADC_CHAN_SETTINGS_SVH
`define ADC_CHAN_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// sample and word widths
////////////////////////////////////////////////////////////////////////////

// raw ADC sample width
`define ADC_BITS 12

// FIFO and readout word width
`define WORD_BITS 16

////////////////////////////////////////////////////////////////////////////
// memory depths and window sizes
////////////////////////////////////////////////////////////////////////////

`define HIST_BITS 10    // history buffer address, 1024 samples
`define FIFO_BITS 7     // output FIFO address, 128 words

// pedestal window is 2**PED_BITS samples
`define PED_BITS 4

`define WIN_BITS 9      // window length field width

`endif

// ==== verilog/adc_chan_pkg.sv ====
`default_nettype none

`include "adc_chan_settings.svh"

package adc_chan_pkg;

	typedef logic [`ADC_BITS-1:0]  adc_sample_t;   // raw ADC sample
	typedef logic [`WORD_BITS-1:0] word_t;         // FIFO and readout word

	// channel configuration, one 32-bit Wishbone register
	typedef struct packed {
		logic [5:0]             chan;       // channel number for the control word
		logic [`WIN_BITS-1:0]   win_len;    // samples per block, zero disables readout
		logic [`HIST_BITS-1:0]  win_beg;    // first sample this many samples before trigger
		logic                   invert;     // 1 gives pedestal minus sample
		logic                   ped_inh;    // freeze the used pedestal
		logic                   trig_mask;  // ignore adc_trig
		logic [3:0]             spare;
	} chan_cfg_t;

	// status register contents
	typedef struct packed {
		logic [`FIFO_BITS:0]    used;       // committed words waiting in the FIFO
		logic [15:0]            missed;     // blocks dropped on a full FIFO
	} chan_status_t;

	// one builder write into the FIFO
	typedef struct packed {
		logic                   we;
		logic [`WIN_BITS-1:0]   offset;     // word position inside the block
		word_t                  data;
		logic                   commit;     // last word, publish the block
	} fifo_wr_t;

	// block builder FSM
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CONTROL,
		ST_TRIGGER,
		ST_TIME,
		ST_COPY,
		ST_COMMIT
	} build_state_t;

	// Wishbone register map
	typedef enum logic [1:0] {
		REG_CONFIG = 2'd0,
		REG_STATUS = 2'd1,
		REG_PED    = 2'd2,
		REG_DATA   = 2'd3
	} wb_reg_e;

endpackage

`default_nettype wire

// ==== verilog/adc_frontend.sv ====
`default_nettype none

`include "adc_chan_settings.svh"

module adc_frontend (
	input  wire                                ADCCLK,
	input  wire                                rst,
	input  wire adc_chan_pkg::adc_sample_t     adc_data,
	input  wire adc_chan_pkg::chan_cfg_t       cfg,
	input  wire [`HIST_BITS-1:0]               hist_raddr,
	output adc_chan_pkg::word_t                hist_rdata,
	output logic [`HIST_BITS-1:0]              hist_waddr,
	output adc_chan_pkg::adc_sample_t          ped
);

	import adc_chan_pkg::*;

	localparam int SUM_BITS = `ADC_BITS + `PED_BITS;   // room for a full window sum
	localparam int PAD_BITS = `WORD_BITS - `ADC_BITS;  // zero extension to word width

	logic [`PED_BITS-1:0]   ped_cnt;    // position inside the pedestal window
	logic [SUM_BITS-1:0]    ped_sum;    // running sum, excludes the current sample
	logic [SUM_BITS-1:0]    win_sum;    // sum including the current sample
	adc_sample_t            ped_mean;   // rounded window mean
	word_t                  pdata;      // pedestal subtracted sample, signed

	word_t                  hist_mem [2**`HIST_BITS];

	////////////////////////////////////////////////////////////////////////////
	// pedestal
	////////////////////////////////////////////////////////////////////////////

	assign win_sum = ped_sum + {{`PED_BITS{1'b0}}, adc_data};

	// drop the fraction bits, add one when the first dropped bit is set
	// so exactly one half rounds up
	assign ped_mean = win_sum[SUM_BITS-1:`PED_BITS]
		+ {{(`ADC_BITS-1){1'b0}}, win_sum[`PED_BITS-1]};

	always_ff @(posedge ADCCLK) begin
		if (rst) begin
			ped_cnt <= '0;
			ped_sum <= '0;
			ped     <= '0;
		end else begin
			ped_cnt <= ped_cnt + 1'b1;          // wraps to start the next window
			if (&ped_cnt) begin
				ped_sum <= '0;                  // last sample of the window
				if (!cfg.ped_inh)
					ped <= ped_mean;            // used copy follows unless frozen
			end else begin
				ped_sum <= win_sum;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// subtraction and history
	////////////////////////////////////////////////////////////////////////////

	// 16-bit two's complement difference of the zero extended values
	always_ff @(posedge ADCCLK) begin
		if (cfg.invert)
			pdata <= {{PAD_BITS{1'b0}}, ped} - {{PAD_BITS{1'b0}}, adc_data};
		else
			pdata <= {{PAD_BITS{1'b0}}, adc_data} - {{PAD_BITS{1'b0}}, ped};
	end

	// free running write pointer, one sample per clock
	always_ff @(posedge ADCCLK) begin
		if (rst)
			hist_waddr <= '0;
		else
			hist_waddr <= hist_waddr + 1'b1;
	end

	// sample seen at edge n lands in memory at edge n+1
	always_ff @(posedge ADCCLK) begin
		hist_mem[hist_waddr] <= pdata;
		hist_rdata           <= hist_mem[hist_raddr];   // read data one clock after address
	end

endmodule

`default_nettype wire

// ==== verilog/event_builder.sv ====
`default_nettype none

`include "adc_chan_settings.svh"

module event_builder (
	input  wire                                ADCCLK,
	input  wire                                rst,
	input  wire adc_chan_pkg::chan_cfg_t       cfg,
	input  wire                                adc_trig,
	input  wire [2:0]                          trig_time,
	input  wire [`HIST_BITS-1:0]               hist_waddr,
	input  wire adc_chan_pkg::word_t           hist_rdata,
	output logic [`HIST_BITS-1:0]              hist_raddr,
	input  wire                                block_fits,
	output adc_chan_pkg::fifo_wr_t             wr,
	output logic [15:0]                        missed_cnt
);

	import adc_chan_pkg::*;

	build_state_t           state;
	logic [`WIN_BITS-1:0]   cnt;        // window samples still to copy
	logic [`HIST_BITS-1:0]  trig_addr;  // history address of the trigger sample
	logic [2:0]             ttime;      // latched fine trigger time
	logic [9:0]             tnum;       // sequential trigger number
	logic                   parity;     // block parity, toggles per block
	logic                   trig_ok;

	assign trig_ok = adc_trig & ~cfg.trig_mask;

	////////////////////////////////////////////////////////////////////////////
	// block FSM
	////////////////////////////////////////////////////////////////////////////

	// wr is registered, so the FIFO sees each word one clock after its state
	// and the commit lands on the edge that leaves ST_COMMIT
	always_ff @(posedge ADCCLK) begin
		if (rst) begin
			state      <= ST_IDLE;
			wr.we      <= 1'b0;
			wr.commit  <= 1'b0;
			tnum       <= '0;
			parity     <= 1'b0;
			missed_cnt <= '0;
		end else begin
			wr.we     <= 1'b0;
			wr.commit <= 1'b0;
			case (state)
			ST_IDLE: begin
				if (trig_ok) begin
					// sample of this edge sits one slot past the write pointer
					trig_addr <= hist_waddr + 1'b1;
					ttime     <= trig_time;
					cnt       <= cfg.win_len;
					if (cfg.win_len == '0) begin
						state <= ST_IDLE;                       // readout off
					end else if (!block_fits) begin
						missed_cnt <= missed_cnt + 16'd1;       // whole block dropped
					end else begin
						state <= ST_CONTROL;
					end
				end
			end
			ST_CONTROL: begin
				wr.we     <= 1'b1;
				wr.offset <= '0;
				wr.data   <= {1'b1, cfg.chan, cnt + `WIN_BITS'd3};   // length counts header words
				state     <= ST_TRIGGER;
			end
			ST_TRIGGER: begin
				wr.we      <= 1'b1;
				wr.offset  <= wr.offset + 1'b1;
				wr.data    <= {1'b0, 3'b001, parity, 1'b0, tnum};     // master type
				hist_raddr <= trig_addr - cfg.win_beg;               // first window sample
				state      <= ST_TIME;
			end
			ST_TIME: begin
				wr.we      <= 1'b1;
				wr.offset  <= wr.offset + 1'b1;
				wr.data    <= {13'd0, ttime};
				hist_raddr <= hist_raddr + 1'b1;    // first sample is on hist_rdata next
				state      <= ST_COPY;
			end
			ST_COPY: begin
				wr.we      <= 1'b1;
				wr.offset  <= wr.offset + 1'b1;
				wr.data    <= {1'b0, hist_rdata[14:0]};   // bit 15 marks control words only
				hist_raddr <= hist_raddr + 1'b1;
				cnt        <= cnt - 1'b1;
				if (cnt == `WIN_BITS'd1) begin
					wr.commit <= 1'b1;
					state     <= ST_COMMIT;
				end
			end
			ST_COMMIT: begin
				// block is published on this edge, so number it now
				tnum   <= tnum + 10'd1;
				parity <= ~parity;
				state  <= ST_IDLE;
			end
			default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/event_fifo.sv ====
`default_nettype none

`include "adc_chan_settings.svh"

module event_fifo (
	input  wire                                ADCCLK,
	input  wire                                rst,
	input  wire adc_chan_pkg::fifo_wr_t        wr,
	input  wire adc_chan_pkg::chan_cfg_t       cfg,
	input  wire                                pop,
	output logic                               block_fits,
	output adc_chan_pkg::word_t                head,
	output logic [`FIFO_BITS:0]                used,
	output logic                               empty
);

	import adc_chan_pkg::*;

	// pointers carry one extra bit so a full FIFO differs from an empty one
	logic [`FIFO_BITS:0]    rd_ptr;
	logic [`FIFO_BITS:0]    blk_end;    // end of committed data, base of the block in progress
	logic [`FIFO_BITS:0]    rd_next;
	logic [`FIFO_BITS:0]    free;
	logic [`WIN_BITS:0]     need;       // words in a full block
	logic [`FIFO_BITS-1:0]  waddr;

	word_t                  fifo_mem [2**`FIFO_BITS];

	assign used  = blk_end - rd_ptr;
	assign empty = (used == '0);
	assign free  = {1'b1, {`FIFO_BITS{1'b0}}} - used;

	// window plus control, trigger and time words
	assign need       = {1'b0, cfg.win_len} + 2'd3;
	assign block_fits = {{(`WIN_BITS-`FIFO_BITS){1'b0}}, free} >= need;

	assign waddr   = blk_end[`FIFO_BITS-1:0] + wr.offset[`FIFO_BITS-1:0];
	assign rd_next = rd_ptr + {{`FIFO_BITS{1'b0}}, pop & ~empty};

	////////////////////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////////////////////

	// head reads ahead so it already shows the next word after a pop
	always_ff @(posedge ADCCLK) begin
		if (wr.we)
			fifo_mem[waddr] <= wr.data;
		head <= fifo_mem[rd_next[`FIFO_BITS-1:0]];
	end

	always_ff @(posedge ADCCLK) begin
		if (rst) begin
			rd_ptr  <= '0;
			blk_end <= '0;
		end else begin
			rd_ptr <= rd_next;
			if (wr.we && wr.commit)
				blk_end <= blk_end + wr.offset[`FIFO_BITS:0] + 1'b1;   // whole block at once
		end
	end

endmodule

`default_nettype wire

// ==== verilog/wb_regs.sv ====
`default_nettype none

`include "adc_chan_settings.svh"

module wb_regs (
	input  wire                                ADCCLK,
	input  wire                                rst,
	input  wire                                wb_cyc,
	input  wire                                wb_stb,
	input  wire                                wb_we,
	input  wire adc_chan_pkg::wb_reg_e         wb_adr,
	input  wire [31:0]                         wb_dat_w,
	output logic [31:0]                        wb_dat_r,
	output logic                               wb_ack,
	input  wire adc_chan_pkg::adc_sample_t     ped,
	input  wire adc_chan_pkg::chan_status_t    status,
	input  wire adc_chan_pkg::word_t           head,
	input  wire                                empty,
	output adc_chan_pkg::chan_cfg_t            cfg,
	output logic                               pop
);

	import adc_chan_pkg::*;

	logic   access;     // new cycle, ack not yet given
	logic   rd_data;    // read of the data register
	word_t  data_word;

	assign access    = wb_cyc & wb_stb & ~wb_ack;
	assign rd_data   = access & ~wb_we & (wb_adr == REG_DATA);
	assign data_word = empty ? '0 : head;   // empty FIFO reads as zero

	////////////////////////////////////////////////////////////////////////////
	// handshake and config
	////////////////////////////////////////////////////////////////////////////

	// ack one clock after cyc and stb, held for a single clock
	always_ff @(posedge ADCCLK) begin
		if (rst) begin
			wb_ack <= 1'b0;
			pop    <= 1'b0;
			cfg    <= '0;
		end else begin
			wb_ack <= access;
			pop    <= rd_data & ~empty;     // FIFO advances as ack ends
			if (access && wb_we && (wb_adr == REG_CONFIG))
				cfg <= wb_dat_w;            // other writes only get an ack
		end
	end

	// read data is valid together with ack
	always_ff @(posedge ADCCLK) begin
		if (access && !wb_we) begin
			case (wb_adr)
			REG_CONFIG: wb_dat_r <= cfg;
			REG_STATUS: wb_dat_r <= {8'd0, status};
			REG_PED:    wb_dat_r <= {{(32-`ADC_BITS){1'b0}}, ped};
			REG_DATA:   wb_dat_r <= {16'd0, data_word};
			default:    wb_dat_r <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/adc_chan_top.sv ====
`default_nettype none

`include "adc_chan_settings.svh"

module adc_chan_top (
	input  wire                                ADCCLK,
	input  wire                                rst,
	input  wire adc_chan_pkg::adc_sample_t     adc_data,
	input  wire                                adc_trig,
	input  wire [2:0]                          trig_time,
	input  wire                                wb_cyc,
	input  wire                                wb_stb,
	input  wire                                wb_we,
	input  wire adc_chan_pkg::wb_reg_e         wb_adr,
	input  wire [31:0]                         wb_dat_w,
	output wire [31:0]                         wb_dat_r,
	output wire                                wb_ack
);

	import adc_chan_pkg::*;

	wire chan_cfg_t             cfg;
	wire [`HIST_BITS-1:0]       hist_raddr;
	wire [`HIST_BITS-1:0]       hist_waddr;
	wire word_t                 hist_rdata;
	wire adc_sample_t           ped;
	wire fifo_wr_t              wr;         // builder to FIFO
	wire                        block_fits;
	wire [15:0]                 missed_cnt;
	wire word_t                 head;
	wire [`FIFO_BITS:0]         used;
	wire                        empty;
	wire                        pop;

	////////////////////////////////////////////////////////////////////////////
	// sample path, block builder, FIFO and register slave
	////////////////////////////////////////////////////////////////////////////

	adc_frontend u_adc_frontend (
		.ADCCLK     (ADCCLK),
		.rst        (rst),
		.adc_data   (adc_data),
		.cfg        (cfg),
		.hist_raddr (hist_raddr),
		.hist_rdata (hist_rdata),
		.hist_waddr (hist_waddr),
		.ped        (ped)
	);

	event_builder u_event_builder (
		.ADCCLK     (ADCCLK),
		.rst        (rst),
		.cfg        (cfg),
		.adc_trig   (adc_trig),
		.trig_time  (trig_time),
		.hist_waddr (hist_waddr),
		.hist_rdata (hist_rdata),
		.hist_raddr (hist_raddr),
		.block_fits (block_fits),
		.wr         (wr),
		.missed_cnt (missed_cnt)
	);

	event_fifo u_event_fifo (
		.ADCCLK     (ADCCLK),
		.rst        (rst),
		.wr         (wr),
		.cfg        (cfg),
		.pop        (pop),
		.block_fits (block_fits),
		.head       (head),
		.used       (used),
		.empty      (empty)
	);

	// status packs used words above the missed count
	wb_regs u_wb_regs (
		.ADCCLK     (ADCCLK),
		.rst        (rst),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.wb_dat_r   (wb_dat_r),
		.wb_ack     (wb_ack),
		.ped        (ped),
		.status     ({used, missed_cnt}),
		.head       (head),
		.empty      (empty),
		.cfg        (cfg),
		.pop        (pop)
	);

endmodule

`default_nettype wire

// ==== verif/tb_adc_chan.sv ====
`default_nettype none

`include "adc_chan_settings.svh"

module tb_adc_chan;

	timeunit 1ns;
	timeprecision 100ps;

	import adc_chan_pkg::*;

	localparam int MAX_CYCLES = 20000;          // limit well above the few thousand cycles the run needs
	localparam int FIFO_WORDS = 2**`FIFO_BITS;
	localparam int SETTLE     = 70;             // history refill after a config change

	logic           ADCCLK = 1'b0;
	logic           rst;
	adc_sample_t    adc_data;
	logic           adc_trig;
	logic [2:0]     trig_time;
	logic           wb_cyc;
	logic           wb_stb;
	logic           wb_we;
	wb_reg_e        wb_adr;
	logic [31:0]    wb_dat_w;
	wire [31:0]     wb_dat_r;
	wire            wb_ack;

	int             cyc = 0;                    // rising edges so far and index into the sample log
	adc_sample_t    samp_log [20480];
	logic [31:0]    sig_lfsr;                   // feeds adc_data
	logic [31:0]    par_lfsr;                   // feeds test parameters
	logic           sig_random;
	adc_sample_t    baseline;
	adc_sample_t    exp_ped;                    // frozen pedestal used by the model
	logic [9:0]     exp_tnum;
	logic           exp_par;
	logic [15:0]    exp_missed;

	adc_chan_top u_adc_chan_top (
		.ADCCLK     (ADCCLK),
		.rst        (rst),
		.adc_data   (adc_data),
		.adc_trig   (adc_trig),
		.trig_time  (trig_time),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.wb_dat_r   (wb_dat_r),
		.wb_ack     (wb_ack)
	);

	initial begin
		forever #50 ADCCLK = ~ADCCLK;   // 100 ns period
	end

	////////////////////////////////////////////////////////////////////////////
	// random source, sample drive and sample log
	////////////////////////////////////////////////////////////////////////////

	// fibonacci form with taps at x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] draw_bits(inout logic [31:0] st, input int nbits);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < nbits; i++) begin
			st = lfsr_step(st);             // one step per bit taken
			r  = {r[30:0], st[0]};
		end
		return r;
	endfunction

	always @(negedge ADCCLK) begin
		logic [31:0] r;
		if (sig_random) begin
			r        = draw_bits(sig_lfsr, `ADC_BITS);
			adc_data = r[`ADC_BITS-1:0];
		end else begin
			adc_data = baseline;            // flat input for the pedestal
		end
	end

	// log what the DUT sees on each edge, and watch the run length
	always @(posedge ADCCLK) begin
		samp_log[cyc] = adc_data;
		cyc           = cyc + 1;
		if (cyc >= MAX_CYCLES) begin
			$display("timeout, run exceeded %0d cycles", MAX_CYCLES);
			$display("sim failed");
			$fatal(1, "cycle limit reached");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model and compare tasks
	////////////////////////////////////////////////////////////////////////////

	// word k of the block for a trigger presented at edge tcyc
	function automatic word_t ref_word(input chan_cfg_t c, input int tcyc, input logic [2:0] tt,
			input logic [9:0] tnum, input logic par, input int k);
		adc_sample_t s;
		word_t       d;
		case (k)
		0: return {1'b1, c.chan, c.win_len + 9'd3};    // length counts the 3 header words
		1: return {4'b0001, par, 1'b0, tnum};
		2: return {13'd0, tt};
		default: ;
		endcase
		s = samp_log[tcyc - int'(c.win_beg) + k - 3];   // window opens win_beg before trigger
		if (c.invert)
			d = {4'd0, exp_ped} - {4'd0, s};
		else
			d = {4'd0, s} - {4'd0, exp_ped};
		return {1'b0, d[14:0]};
	endfunction

	function automatic chan_status_t mk_status(input int used_w, input logic [15:0] missed);
		chan_status_t s;
		s.used   = used_w[`FIFO_BITS:0];
		s.missed = missed;
		return s;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp)
			abort_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_status(input string name, input chan_status_t exp,
			input chan_status_t act);
		if (act !== exp)
			abort_run($sformatf("Fail %s expected used %0d missed %0d actual used %0d missed %0d",
				name, exp.used, exp.missed, act.used, act.missed));
	endtask

	task automatic check_ped(input string name, input adc_sample_t exp, input adc_sample_t act);
		if (act !== exp)
			abort_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// bus and trigger tasks
	////////////////////////////////////////////////////////////////////////////

	// classic cycle held until ack and released on the falling edge that sees it
	task automatic wb_access(input wb_reg_e adr, input logic we, input logic [31:0] wdat,
			output logic [31:0] rdat);
		@(negedge ADCCLK);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdat;
		@(negedge ADCCLK);
		while (!wb_ack)
			@(negedge ADCCLK);
		rdat   = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_read(input wb_reg_e adr, output logic [31:0] rdat);
		wb_access(adr, 1'b0, 32'd0, rdat);
	endtask

	task automatic write_cfg(input chan_cfg_t c);
		logic [31:0] unused_rd;
		wb_access(REG_CONFIG, 1'b1, c, unused_rd);
	endtask

	task automatic read_status(output chan_status_t st);
		logic [31:0] rd;
		wb_read(REG_STATUS, rd);
		st = rd[23:0];
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge ADCCLK);
	endtask

	task automatic fire_trigger(input logic [2:0] tt, output int tcyc);
		@(negedge ADCCLK);
		adc_trig  = 1'b1;
		trig_time = tt;
		tcyc      = cyc;                    // index of the edge that takes the trigger
		@(negedge ADCCLK);
		adc_trig  = 1'b0;
	endtask

	// poll until exp; anything other than prev on the way is a partial block
	task automatic wait_status(input string name, input chan_status_t prev,
			input chan_status_t exp);
		chan_status_t st;
		int           polls;
		polls = 0;
		read_status(st);
		while (st !== exp) begin
			if (st !== prev || polls == 100)
				check_status(name, exp, st);
			polls++;
			read_status(st);
		end
	endtask

	task automatic random_cfg(input logic inv, output chan_cfg_t c);
		logic [31:0] r;
		c         = '0;
		c.ped_inh = 1'b1;                   // pedestal stays at the baseline
		c.invert  = inv;
		r         = draw_bits(par_lfsr, 6);
		c.chan    = r[5:0];
		r         = draw_bits(par_lfsr, 5);
		c.win_len = 9'(r % 20 + 1);         // 1 to 20 samples
		r         = draw_bits(par_lfsr, 6);
		c.win_beg = {4'd0, r[5:0]};
	endtask

	task automatic read_block(input string name, input chan_cfg_t c, input int tcyc,
			input logic [2:0] tt, input logic [9:0] tnum, input logic par);
		logic [31:0] rd;
		for (int k = 0; k < int'(c.win_len) + 3; k++) begin
			wb_read(REG_DATA, rd);
			check_word(name, ref_word(c, tcyc, tt, tnum, par, k), rd[15:0]);
		end
	endtask

	task automatic single_block(input string name, input logic inv);
		chan_cfg_t    c;
		chan_status_t st;
		logic [31:0]  r;
		logic [2:0]   tt;
		int           tcyc;
		random_cfg(inv, c);
		write_cfg(c);
		idle_cycles(SETTLE);
		r  = draw_bits(par_lfsr, 3);
		tt = r[2:0];
		fire_trigger(tt, tcyc);
		wait_status(name, mk_status(0, exp_missed), mk_status(int'(c.win_len) + 3, exp_missed));
		read_block(name, c, tcyc, tt, exp_tnum, exp_par);
		exp_tnum = exp_tnum + 10'd1;        // numbered per committed block
		exp_par  = ~exp_par;
		read_status(st);
		check_status(name, mk_status(0, exp_missed), st);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		chan_cfg_t    c;
		chan_status_t st;
		logic [31:0]  rd;
		logic [2:0]   tt;
		int           tcyc;
		int           used_w;
		int           q_tcyc [$];
		logic [2:0]   q_tt [$];

		rst        = 1'b1;
		adc_data   = '0;
		adc_trig   = 1'b0;
		trig_time  = '0;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = REG_CONFIG;
		wb_dat_w   = '0;
		sig_random = 1'b0;
		baseline   = '0;
		sig_lfsr   = 32'hd55c;
		par_lfsr   = 32'hd55c;
		exp_ped    = '0;
		exp_tnum   = '0;
		exp_par    = 1'b0;
		exp_missed = '0;
		repeat (8) @(negedge ADCCLK);
		rst = 1'b0;

		// reset state
		read_status(st);
		check_status("reset status", mk_status(0, 16'd0), st);
		wb_read(REG_PED, rd);
		check_ped("reset pedestal", '0, rd[`ADC_BITS-1:0]);
		wb_read(REG_DATA, rd);
		check_word("empty data read", '0, rd[15:0]);

		// pedestal tracks a flat baseline, then freezes
		rd       = draw_bits(par_lfsr, `ADC_BITS);
		baseline = rd[`ADC_BITS-1:0];
		idle_cycles(64);
		wb_read(REG_PED, rd);
		check_ped("pedestal baseline", baseline, rd[`ADC_BITS-1:0]);
		c         = '0;
		c.ped_inh = 1'b1;
		write_cfg(c);
		sig_random = 1'b1;
		idle_cycles(64);
		wb_read(REG_PED, rd);
		check_ped("pedestal frozen", baseline, rd[`ADC_BITS-1:0]);
		exp_ped = baseline;

		for (int b = 0; b < 3; b++)
			single_block("triggered block", 1'b0);
		for (int b = 0; b < 2; b++)
			single_block("inverted block", 1'b1);

		// fill the FIFO with 23-word blocks and count the refusals
		random_cfg(1'b0, c);
		c.win_len = 9'd20;
		write_cfg(c);
		idle_cycles(SETTLE);
		used_w = 0;
		for (int t = 0; t < 8; t++) begin
			rd = draw_bits(par_lfsr, 3);
			tt = rd[2:0];
			st = mk_status(used_w, exp_missed);
			fire_trigger(tt, tcyc);
			if (FIFO_WORDS - used_w >= int'(c.win_len) + 3) begin
				used_w += int'(c.win_len) + 3;
				q_tcyc.push_back(tcyc);
				q_tt.push_back(tt);
			end else begin
				exp_missed = exp_missed + 16'd1;    // whole block dropped
			end
			wait_status("back-pressure", st, mk_status(used_w, exp_missed));
		end
		while (q_tcyc.size() > 0) begin
			read_block("drained block", c, q_tcyc.pop_front(), q_tt.pop_front(),
				exp_tnum, exp_par);
			exp_tnum = exp_tnum + 10'd1;
			exp_par  = ~exp_par;
		end
		read_status(st);
		check_status("drained status", mk_status(0, exp_missed), st);
		single_block("block after drain", 1'b0);

		// zero window and masked trigger give nothing
		c.win_len = '0;
		write_cfg(c);
		fire_trigger(3'd5, tcyc);
		idle_cycles(30);
		read_status(st);
		check_status("zero window", mk_status(0, exp_missed), st);
		c.win_len   = 9'd5;
		c.trig_mask = 1'b1;
		write_cfg(c);
		fire_trigger(3'd2, tcyc);
		idle_cycles(30);
		read_status(st);
		check_status("masked trigger", mk_status(0, exp_missed), st);
		single_block("block after mask", 1'b0);

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+verilog
verilog/adc_chan_pkg.sv
verilog/adc_frontend.sv
verilog/event_builder.sv
verilog/event_fifo.sv
verilog/wb_regs.sv
verilog/adc_chan_top.sv
verif/tb_adc_chan.sv

// ==== Makefile ====
# Verilator build, run and lint for the ADC channel testbench

VERILATOR  ?= verilator
TOP        ?= tb_adc_chan
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --timescale 1ns/100ps -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/100ps -Wall

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS) verilog/adc_chan_settings.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# exit status of the simulation is the test result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
